// ==== aluGolden.txt ====
// opA opB sel mode carryInN | result carryOutN aEqB groupP groupG, all hex
// arithmetic entries first, then every logic select on ff00 and f0f0
1234 4321 9 0 1 5555 1 0 1 1
1234 4321 9 0 0 5556 1 0 1 1
00ff 0001 9 0 1 0100 1 0 1 1
ffff 0001 9 0 1 0000 0 0 0 0
ffff 0000 9 0 0 0000 0 0 0 1
ffff 0000 9 0 1 ffff 1 1 0 1
8000 8000 9 0 1 0000 0 0 1 0
5678 1234 6 0 0 4444 0 0 1 0
5678 5678 6 0 0 0000 0 0 0 1
5678 5678 6 0 1 ffff 1 1 0 1
1234 5678 6 0 0 bbbc 1 0 1 1
0000 0000 6 0 1 ffff 1 1 0 1
0000 0001 6 0 0 ffff 1 1 1 1
abcd 1111 0 0 1 abcd 1 0 1 1
ffff 0000 0 0 0 0000 0 0 0 1
1000 0000 f 0 1 0fff 0 0 0 0
0000 0000 f 0 1 ffff 1 1 0 1
4321 0000 c 0 0 8643 1 0 1 1
c000 0000 c 0 1 8000 0 0 1 0
2468 1357 3 0 1 ffff 1 1 0 1
ff00 f0f0 0 1 0 00ff 1 0 1 1
ff00 f0f0 1 1 0 000f 1 0 1 1
ff00 f0f0 2 1 0 00f0 1 0 1 1
ff00 f0f0 3 1 0 0000 0 0 0 1
ff00 f0f0 4 1 0 0fff 0 0 1 0
ff00 f0f0 5 1 0 0f0f 0 0 1 0
ff00 f0f0 6 1 0 0ff0 0 0 1 0
ff00 f0f0 7 1 0 0f00 0 0 0 0
ff00 f0f0 8 1 1 f0ff 0 0 1 0
ff00 f0f0 9 1 1 f00f 0 0 1 0
ff00 f0f0 a 1 1 f0f0 0 0 1 0
ff00 f0f0 b 1 1 f000 0 0 0 0
ff00 f0f0 c 1 1 ffff 0 1 1 0
ff00 f0f0 d 1 1 ff0f 0 0 1 0
ff00 f0f0 e 1 1 fff0 0 0 1 0
ff00 f0f0 f 1 1 ff00 0 0 0 0

// ==== sources.f ====
aluPkg.sv
opQueue.sv
aluSlice.sv
carryLookahead.sv
resultStage.sv
aluTop.sv
aluTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the ALU testbench with Verilator and runs it from the project root
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module aluTb -o aluSim

./obj_dir/aluSim | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation log is in sim.log"

// ==== aluTb.sv ====
// testbench for the 16-bit ALU, replays golden operations under input and output credit rules
`timescale 1ns/100ps

module aluTb;
	import aluPkg::*;

	localparam int numOps = 36; // operations in the golden file
	localparam int fieldsPerOp = 10; // hex tokens on each golden line
	localparam int timeoutCycles = 2000;
	localparam int pauseAt = 12; // results seen before the consumer stops granting
	localparam int pauseLen = 40;
	localparam logic [31:0] lfsrSeed = 32'h330db049;

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	wordT opA;
	wordT opB;
	selT  sel;
	logic mode;
	logic carryInN;
	logic inCredit;
	logic outCredit;
	logic outValid;
	wordT result;
	logic carryOutN;
	logic aEqB;
	logic groupP;
	logic groupG;

	// operands, select, mode and carry-in first, then the five expected result fields
	logic [15:0] goldMem [0:numOps*fieldsPerOp-1];

	logic [31:0] lfsrState;
	logic started; // driver stays idle until reset is over
	logic sendBit0;
	logic sendBit1;
	logic grantBit;
	logic pauseDone;
	int pauseLeft;
	int sendIdx;
	int acceptCnt; // beats the queue took
	int inCreditCnt;
	int grantCnt; // outCredit pulses given
	int outCount; // results received so far
	int resetEdges;
	int errCount;
	int checkCount;
	int waitCycles;
	int base;

	aluTop dut0 (
		.clk, .rstN, .inValid, .opA, .opB, .sel, .mode, .carryInN, .inCredit,
		.outCredit, .outValid, .result, .carryOutN, .aEqB, .groupP, .groupG
	);

	always #20 clk = ~clk;

	// fibonacci form with taps at 32, 22, 2 and 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic nextBit(output logic b);
		lfsrState = lfsrNext(lfsrState); // one step for each bit used
		b = lfsrState[0];
	endtask

	task automatic checkField(input string name, input int idx, input logic [15:0] expVal,
			input logic [15:0] actVal);
		checkCount++;
		assert (actVal === expVal)
		else begin
			errCount++;
			$display("CHECK FAILED %s op %0d: expected %h, actual %h", name, idx, expVal,
				actVal);
		end
	endtask

	// everything is sampled at the rising edge, where the DUT registers are still stable
	always @(posedge clk) begin
		if (!rstN) begin
			if (resetEdges > 0) begin // outputs are unknown before the first reset edge
				assert (outValid === 1'b0 && inCredit === 1'b0)
				else begin
					errCount++;
					$display("outValid or inCredit went high during reset");
				end
			end
			resetEdges++;
		end else begin
			if (inCredit) begin
				inCreditCnt++;
				// a credit can only come back for a beat taken at an earlier edge
				assert (inCreditCnt <= acceptCnt)
				else begin
					errCount++;
					$display("inCredit returned more credits than operations accepted");
				end
			end
			if (inValid)
				acceptCnt++; // the producer only sends while it holds a credit
			if (outValid) begin
				if (outCount >= numOps) begin
					errCount++;
					$display("a result arrived after all operations were answered");
				end else begin
					base = outCount * fieldsPerOp; // results must come back in file order
					checkField("result", outCount, goldMem[base+5], result);
					checkField("carryOutN", outCount, {15'b0, goldMem[base+6][0]},
						{15'b0, carryOutN});
					checkField("aEqB", outCount, {15'b0, goldMem[base+7][0]},
						{15'b0, aEqB});
					checkField("groupP", outCount, {15'b0, goldMem[base+8][0]},
						{15'b0, groupP});
					checkField("groupG", outCount, {15'b0, goldMem[base+9][0]},
						{15'b0, groupG});
				end
				outCount++;
				assert (outCount <= grantCnt)
				else begin
					errCount++;
					$display("more results than output credits granted");
				end
			end
			if (outCredit)
				grantCnt++;
		end
	end

	// producer and consumer share one driver so the random sequence has a fixed order
	always @(posedge clk) begin
		#1;
		inValid = 1'b0;
		outCredit = 1'b0;
		if (started) begin
			nextBit(sendBit0);
			nextBit(sendBit1);
			// the producer idles about one cycle in four
			if (sendIdx < numOps && acceptCnt - inCreditCnt < queueDepth
					&& (sendBit0 || sendBit1)) begin
				inValid = 1'b1;
				opA = goldMem[sendIdx*fieldsPerOp];
				opB = goldMem[sendIdx*fieldsPerOp+1];
				sel = goldMem[sendIdx*fieldsPerOp+2][3:0];
				mode = goldMem[sendIdx*fieldsPerOp+3][0];
				carryInN = goldMem[sendIdx*fieldsPerOp+4][0];
				sendIdx++;
			end
			if (!pauseDone && outCount >= pauseAt) begin
				pauseLeft = pauseLen; // long stretch without grants
				pauseDone = 1'b1;
			end
			if (pauseLeft > 0) begin
				pauseLeft--;
				if (pauseLeft == 0) begin
					// every granted credit is spent and no further result came out
					assert (outCount == grantCnt)
					else begin
						errCount++;
						$display("results did not stop at the granted credits during the pause");
					end
				end
			end else begin
				nextBit(grantBit);
				if (grantCnt - outCount < outCreditMax && grantBit)
					outCredit = 1'b1;
			end
		end
	end

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		opA = '0;
		opB = '0;
		sel = '0;
		mode = 1'b0;
		carryInN = 1'b1;
		outCredit = 1'b0;
		started = 1'b0;
		pauseDone = 1'b0;
		pauseLeft = 0;
		sendIdx = 0;
		acceptCnt = 0;
		inCreditCnt = 0;
		grantCnt = 0;
		outCount = 0;
		resetEdges = 0;
		errCount = 0;
		checkCount = 0;
		lfsrState = lfsrSeed;
		$readmemh("aluGolden.txt", goldMem);

		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(posedge clk);
		started = 1'b1; // first drive happens 1 ns after this edge
		#1;
		assert (outValid === 1'b0 && inCredit === 1'b0) // nothing sent yet
		else begin
			errCount++;
			$display("outValid or inCredit high right after reset");
		end

		waitCycles = 0;
		while (outCount < numOps && waitCycles < timeoutCycles) begin
			@(posedge clk);
			#1; // counts settle in the monitor at the edge itself
			waitCycles++;
		end
		if (outCount < numOps) begin
			errCount++;
			$display("timed out after %0d cycles with %0d of %0d results", waitCycles, outCount,
				numOps);
		end
		repeat (8) @(posedge clk); // lets any stray pulse show up in the counts

		assert (acceptCnt == numOps && outCount == numOps)
		else begin
			errCount++;
			$display("accepted %0d and received %0d, expected %0d each", acceptCnt, outCount,
				numOps);
		end
		assert (inCreditCnt == acceptCnt)
		else begin
			errCount++;
			$display("%0d inCredit pulses for %0d accepted operations", inCreditCnt, acceptCnt);
		end

		$display("checks %0d, errors %0d, results %0d, grants %0d", checkCount, errCount, outCount,
			grantCnt);
		if (errCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== aluTop.sv ====
// top level of the 16-bit registered ALU, four 74181 slices linked by a 74182 lookahead
`timescale 1ns/100ps

module aluTop (
	input  logic         clk,
	input  logic         rstN,
	input  logic         inValid,
	input  aluPkg::wordT opA,
	input  aluPkg::wordT opB,
	input  aluPkg::selT  sel,
	input  logic         mode,
	input  logic         carryInN,
	output logic         inCredit,
	input  logic         outCredit,
	output logic         outValid,
	output aluPkg::wordT result,
	output logic         carryOutN,
	output logic         aEqB,
	output logic         groupP,
	output logic         groupG
);
	import aluPkg::*;

	logic issueValid;
	wordT issueA;
	wordT issueB;
	selT  issueSel;
	logic issueMode;
	logic issueCarryInN;
	logic drainReady;

	wordT sliceF; // nibbles from all slices side by side
	logic [numSlices-1:0] sliceEq;
	logic [numSlices-1:0] sliceXN;
	logic [numSlices-1:0] sliceYN;
	logic [numSlices-1:0] sliceCarryInN;
	logic laCarryOutN; // lookahead outputs before the result register
	logic laGroupP;
	logic laGroupG;

	opQueue queue0 (
		.clk, .rstN, .inValid, .opA, .opB, .sel, .mode, .carryInN, .drainReady,
		.inCredit, .issueValid, .issueA, .issueB, .issueSel, .issueMode, .issueCarryInN
	);

	// slice i works on bits 4i+3..4i, the carry comes back from the lookahead
	for (genvar i = 0; i < numSlices; i++) begin : gSlice
		aluSlice slice (
			.a(issueA[i*sliceWidth +: sliceWidth]),
			.b(issueB[i*sliceWidth +: sliceWidth]),
			.sel(issueSel),
			.mode(issueMode),
			.carryInN(sliceCarryInN[i]),
			.f(sliceF[i*sliceWidth +: sliceWidth]),
			.aEqB(sliceEq[i]),
			.xN(sliceXN[i]),
			.yN(sliceYN[i])
		);
	end

	carryLookahead lookahead0 (
		.carryInN(issueCarryInN), .xN(sliceXN), .yN(sliceYN),
		.sliceCarryInN, .carryOutN(laCarryOutN), .groupP(laGroupP), .groupG(laGroupG)
	);

	resultStage result0 (
		.clk, .rstN, .outCredit, .issueValid, .sliceF, .sliceEq,
		.carryOutN(laCarryOutN), .groupP(laGroupP), .groupG(laGroupG),
		.drainReady, .outValid, .result, .resultCarryOutN(carryOutN), .aEqB,
		.resultP(groupP), .resultG(groupG)
	);

endmodule

// ==== resultStage.sv ====
// output register with the consumer credit counter, assembles the 16-bit ALU result
`timescale 1ns/100ps

module resultStage (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         outCredit, // one grant per pulse
	input  logic                         issueValid, // slices hold a live operation
	input  aluPkg::wordT                 sliceF,
	input  logic [aluPkg::numSlices-1:0] sliceEq,
	input  logic                         carryOutN,
	input  logic                         groupP,
	input  logic                         groupG,
	output logic                         drainReady,
	output logic                         outValid,
	output aluPkg::wordT                 result,
	output logic                         resultCarryOutN,
	output logic                         aEqB,
	output logic                         resultP,
	output logic                         resultG
);
	import aluPkg::*;

	logic [creditCntWidth-1:0] creditCnt; // grants not yet spent on a result
	logic [creditCntWidth-1:0] committed; // grant already claimed by the issue in flight

	// an issue in the slices has taken its credit but the counter only drops at its edge
	assign committed = creditCntWidth'(issueValid);
	assign drainReady = creditCnt > committed;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			creditCnt <= '0;
		end else begin
			case ({outCredit, issueValid})
				2'b10: creditCnt <= creditCnt + 1'b1; // fresh grant
				2'b01: creditCnt <= creditCnt - 1'b1; // result spends one
				default: creditCnt <= creditCnt; // both or neither, count holds
			endcase
		end
	end

	// result fields are captured at the edge that ends the issue cycle
	always_ff @(posedge clk) begin
		if (issueValid) begin
			result <= sliceF;
			resultCarryOutN <= carryOutN;
			aEqB <= &sliceEq; // the chips wire-AND their A=B outputs
			resultP <= groupP;
			resultG <= groupG;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= issueValid; // one pulse per result
	end

	// the consumer never has more grants outstanding than it is allowed
	assert property (@(posedge clk) disable iff (!rstN)
		creditCnt <= creditCntWidth'(outCreditMax))
		else $error("resultStage: credit count above outCreditMax");

	// the queue only pops against a credit, so an issue always finds one
	assert property (@(posedge clk) disable iff (!rstN)
		issueValid |-> creditCnt != '0)
		else $error("resultStage: issue without an output credit");

endmodule

// ==== carryLookahead.sv ====
// 74182-style lookahead that forms slice carry-ins and the group carry, propagate and generate
`timescale 1ns/100ps

module carryLookahead (
	input  logic                         carryInN, // external carry, active low
	input  logic [aluPkg::numSlices-1:0] xN, // slice propagate, active low
	input  logic [aluPkg::numSlices-1:0] yN, // slice generate, active low
	output logic [aluPkg::numSlices-1:0] sliceCarryInN,
	output logic                         carryOutN,
	output logic                         groupP, // active low
	output logic                         groupG // active low
);
	import aluPkg::*;

	logic [numSlices-1:0] p; // active-high slice propagate
	logic [numSlices-1:0] g; // active-high slice generate
	logic c0;
	logic c1;
	logic c2;
	logic c3;
	logic genP;
	logic genG;

	assign p = ~xN;
	assign g = ~yN;
	assign c0 = ~carryInN;

	// Cn+x, Cn+y and Cn+z of the 74182, all from terms below the slice
	assign c1 = g[0] | (p[0] & c0);
	assign c2 = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0);
	assign c3 = g[2]
		| (p[2] & g[1])
		| (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & c0);

	// group terms let a further 74182 level cascade, even though none exists here
	assign genP = &p;
	assign genG = g[3]
		| (p[3] & g[2])
		| (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);

	// slice 0 takes the external carry unchanged
	assign sliceCarryInN = {~c3, ~c2, ~c1, carryInN};

	assign carryOutN = ~(genG | (genP & c0)); // carry out of the whole word
	assign groupP = ~genP;
	assign groupG = ~genG;

endmodule

// ==== aluSlice.sv ====
// one 4-bit 74181-style slice with function output, A=B term and active-low P/G
`timescale 1ns/100ps

module aluSlice (
	input  aluPkg::nibbleT a,
	input  aluPkg::nibbleT b,
	input  aluPkg::selT    sel,
	input  logic           mode, // high selects logic functions
	input  logic           carryInN, // active low, from the lookahead unit
	output aluPkg::nibbleT f,
	output logic           aEqB,
	output logic           xN, // active-low group propagate
	output logic           yN // active-low group generate
);
	import aluPkg::*;

	nibbleT e; // per-bit not-generate term, S3 and S2 pick the A and B mix
	nibbleT d; // per-bit not-propagate term, S1 and S0 pick the B mix
	nibbleT c; // active-high carry into each bit
	nibbleT cMasked;

	// the first level of the 74181, two NOR gates per bit
	assign e = ~((a & b & {sliceWidth{sel[3]}}) | (a & ~b & {sliceWidth{sel[2]}}));
	assign d = ~((~b & {sliceWidth{sel[1]}}) | (b & {sliceWidth{sel[0]}}) | a);

	// ripple inside the nibble, d high always implies e high so g implies p
	always_comb begin
		c[0] = ~carryInN;
		for (int i = 1; i < sliceWidth; i++) begin
			c[i] = ~e[i-1] | (~d[i-1] & c[i-1]); // g | p & c
		end
	end

	// mode high blocks the carries, each bit then becomes a pure function of a and b
	assign cMasked = c | {sliceWidth{mode}};

	// e ^ d is a ^ b in add mode, so this is the usual sum bit
	assign f = (e ^ d) ^ cMasked;

	// open-collector A=B on the chip, only meaningful in subtract mode
	assign aEqB = &f;

	// propagate over the whole nibble, independent of the carry-in
	assign xN = |d;

	// generate chain from the top bit down, also independent of the carry-in
	assign yN = d[3]
		| (e[3] & d[2])
		| (e[3] & e[2] & d[1])
		| (e[3] & e[2] & e[1] & e[0]);

endmodule

// ==== opQueue.sv ====
// credit-controlled input FIFO that holds pending ALU operations and issues the head entry
`timescale 1ns/100ps

module opQueue (
	input  logic         clk,
	input  logic         rstN,
	input  logic         inValid, // one beat per producer credit
	input  aluPkg::wordT opA,
	input  aluPkg::wordT opB,
	input  aluPkg::selT  sel,
	input  logic         mode,
	input  logic         carryInN,
	input  logic         drainReady, // result stage has a free credit
	output logic         inCredit, // one pulse per entry that leaves
	output logic         issueValid,
	output aluPkg::wordT issueA,
	output aluPkg::wordT issueB,
	output aluPkg::selT  issueSel,
	output logic         issueMode,
	output logic         issueCarryInN
);
	import aluPkg::*;

	// entry storage, one array per field
	wordT memA [0:queueDepth-1];
	wordT memB [0:queueDepth-1];
	selT  memSel [0:queueDepth-1];
	logic [queueDepth-1:0] memMode;
	logic [queueDepth-1:0] memCarryInN;

	logic [queuePtrWidth-1:0] wrPtr; // next slot to fill
	logic [queuePtrWidth-1:0] rdPtr; // head entry
	logic [queueCntWidth-1:0] count; // number of held entries

	logic pop; // head leaves at this edge
	logic popQ; // registered pop, marks the issue cycle

	// an entry written at one edge can leave at the next one at the earliest
	assign pop = (count != '0) && drainReady;

	always_ff @(posedge clk) begin
		if (inValid) begin // producer credits keep this from hitting a full queue
			memA[wrPtr] <= opA;
			memB[wrPtr] <= opB;
			memSel[wrPtr] <= sel;
			memMode[wrPtr] <= mode;
			memCarryInN[wrPtr] <= carryInN;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (inValid)
				wrPtr <= wrPtr + 1'b1; // depth is a power of two so the pointer just wraps
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (inValid && !pop)
				count <= count + 1'b1;
			else if (!inValid && pop)
				count <= count - 1'b1;
		end
	end

	// issue register feeds the slices for exactly one cycle per pop
	always_ff @(posedge clk) begin
		if (pop) begin
			issueA <= memA[rdPtr];
			issueB <= memB[rdPtr];
			issueSel <= memSel[rdPtr];
			issueMode <= memMode[rdPtr];
			issueCarryInN <= memCarryInN[rdPtr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			popQ <= 1'b0;
		else
			popQ <= pop;
	end

	assign issueValid = popQ;
	assign inCredit = popQ; // the freed slot goes back to the producer as a credit

	// a write into a full queue means the producer spent a credit it did not have
	assert property (@(posedge clk) disable iff (!rstN)
		inValid |-> (count != queueCntWidth'(queueDepth) || pop))
		else $error("opQueue: write while full, producer credit violation");

	// occupancy never leaves its range across any sequence of writes and pops
	assert property (@(posedge clk) disable iff (!rstN)
		count <= queueCntWidth'(queueDepth))
		else $error("opQueue: occupancy above queueDepth");

endmodule

// ==== aluPkg.sv ====
// shared sizing constants and vector types for the 16-bit 74181/74182 ALU
package aluPkg;

	// datapath sizing
	localparam int dataWidth = 16; // operand and result width
	localparam int sliceWidth = 4; // one 74181 slice handles a nibble
	localparam int numSlices = dataWidth / sliceWidth; // four slices under one 74182

	// input FIFO sizing, the producer also starts with this many credits
	localparam int queueDepth = 4;
	localparam int queuePtrWidth = $clog2(queueDepth); // read and write pointer width
	localparam int queueCntWidth = $clog2(queueDepth + 1); // occupancy has to reach queueDepth

	// output side credit accounting
	localparam int outCreditMax = 4; // most grants the consumer may have outstanding
	localparam int creditCntWidth = $clog2(outCreditMax + 1);

	// full operand or result word
	typedef logic [dataWidth-1:0] wordT;

	// slice operands and function output
	typedef logic [sliceWidth-1:0] nibbleT;

	// 74181 function select S3..S0
	typedef logic [3:0] selT;

	// the select only makes sense as four bits, so the slice width is tied to it
	// and a change of sliceWidth here breaks the slice equations on purpose

	// note that numSlices is derived so the lookahead ports stay consistent
	// with the word width, one 74182 serves at most four slices

	// credit and occupancy counters share a width rule, enough bits for the
	// full count including the top value itself

	// mode encoding follows the 74181 pin M
	// low selects arithmetic with carries, high selects the bitwise functions

	// carry conventions follow the chip with active-high data
	// carry-in and carry-out are active low, X and Y are active-low P and G

endpackage
